//--- all.f
hw/icache_pkg.sv
hw/icache_req_stage.sv
hw/icache_tagv_array.sv
hw/icache_data_lru.sv
hw/icache_ctrl_fsm.sv
hw/icache_top.sv
verif/icache_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := icache_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
PASS_MSG  := TEST RESULT: PASS

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/icache_stim.txt
# columns: op address(hex, byte) miss
# op is fetch, init, inval or hitinv; miss is 1 when a fetch must refill its line
# cold misses, then hits in the same line
fetch  00000008 1
fetch  00000000 0
fetch  0000000c 0
fetch  00000014 1
fetch  00000010 0
# lru in set 3, tags 1 2 1 3 1 2
fetch  00000130 1
fetch  00000234 1
fetch  00000138 0
fetch  0000033c 1
fetch  00000130 0
fetch  00000230 1
# invalidate hit in set 5
fetch  00000150 1
fetch  00000254 1
hitinv 00000158 0
fetch  00000258 0
fetch  0000015c 1
hitinv 00000350 0
fetch  00000150 0
fetch  00000250 0
# init index and invalidate index, way from address bit 0
fetch  00000160 1
fetch  00000264 1
init   00000061 0
fetch  00000168 0
fetch  00000268 1
fetch  00000170 1
fetch  00000274 1
inval  00000070 0
fetch  00000278 0
fetch  0000017c 1
init   00000560 0
fetch  00000264 0
fetch  00000160 1
# back-to-back hits, then one more refill
fetch  00000004 0
fetch  00000134 0
fetch  0000023c 0
fetch  00000018 0
fetch  0000015c 0
fetch  00000254 0
fetch  0000027c 0
fetch  00000170 0
fetch  00000168 0
fetch  00000400 1
fetch  00000404 0
fetch  00000008 0

//--- verif/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;
    import icache_pkg::*;

    localparam int timeout_cycles = 200;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    icache_req_t req;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_data;
    wb_m2s_t     wb_m2s;
    logic        wb_ack;
    logic [31:0] wb_dat;

    logic [31:0] exp_addr_q [$];   // outstanding fetches with the oldest first
    logic        exp_miss_q [$];
    int          exp_cycle_q [$];  // cycle count seen when the fetch was accepted
    int          cycle_cnt = 0;
    int          ack_cnt   = 0;    // acks for the fetch at the head
    int          ack_wait  = -1;

    icache_top #(
        .index_width  (4),
        .offset_width (2)
    ) dut_i (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .wb_m2s     (wb_m2s),
        .wb_ack     (wb_ack),
        .wb_dat     (wb_dat)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory contents and error exit
    ////////////////////////////////////////////////////////////////////////////

    // inverted word address on top and word address below
    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        logic [15:0] wa;
        wa = byte_addr[17:2];
        return {~wa, wa};
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // response monitor and wishbone slave on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_response();
        logic [31:0] addr;
        logic        miss;
        int          acc_cycle;
        if (resp_valid) begin
            assert (exp_addr_q.size() > 0)
                else stop_run("response arrived with no fetch outstanding");
            addr      = exp_addr_q.pop_front();
            miss      = exp_miss_q.pop_front();
            acc_cycle = exp_cycle_q.pop_front();
            assert (resp_data == mem_word(addr))
                else stop_run($sformatf("Fail resp_data: addr %h got %h expected %h",
                                        addr, resp_data, mem_word(addr)));
            assert (ack_cnt == (miss ? 4 : 0))
                else stop_run($sformatf("Fail wb_ack count: addr %h got %h expected %h",
                                        addr, ack_cnt, miss ? 4 : 0));
            if (!miss) begin
                // hit answered in the lookup cycle right after acceptance
                assert (cycle_cnt == acc_cycle + 1)
                    else stop_run($sformatf("hit on %h was not answered in its lookup cycle",
                                            addr));
            end
            ack_cnt = 0;
        end
    endtask

    task automatic serve_wishbone();
        logic [31:0] head;
        logic [31:0] exp_adr;
        if (wb_ack) begin
            wb_ack   = 1'b0;   // single-cycle ack
            ack_wait = -1;
        end else if (wb_m2s.cyc && wb_m2s.stb) begin
            if (ack_wait < 0) begin
                ack_wait = int'($urandom % 3);
            end
            if (ack_wait == 0) begin
                assert (exp_addr_q.size() > 0)
                    else stop_run("wishbone read with no fetch outstanding");
                head    = exp_addr_q[0];
                exp_adr = {head[31:4], 4'h0} + 32'(ack_cnt * 4);   // walks up from line base
                assert (wb_m2s.adr == exp_adr)
                    else stop_run($sformatf("Fail wb_m2s.adr: got %h expected %h",
                                            wb_m2s.adr, exp_adr));
                assert (!wb_m2s.we) else stop_run("write cycle seen on the refill port");
                wb_dat   = mem_word(wb_m2s.adr);
                wb_ack   = 1'b1;
                ack_cnt++;
                ack_wait = -1;
            end else begin
                ack_wait--;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstn) begin
            check_response();
            serve_wishbone();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request driver
    ////////////////////////////////////////////////////////////////////////////

    // called on a falling edge and returns one falling edge after the transfer
    task automatic send_request(input cache_op_e op, input logic [31:0] addr,
                                input logic miss);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req.op    = op;
        req.addr  = addr;
        while (!req_ready) begin
            waited++;
            assert (waited < timeout_cycles)
                else stop_run($sformatf("timeout waiting for req_ready, addr %h", addr));
            @(negedge clk);
        end
        if (op == op_fetch) begin
            exp_addr_q.push_back(addr);
            exp_miss_q.push_back(miss);
            exp_cycle_q.push_back(cycle_cnt);
        end
        @(negedge clk);
    endtask

    initial begin
        string       line;
        string       op_name;
        int          fd;
        int          n;
        int          miss;
        int          waited;
        int unsigned seed;
        logic [31:0] addr;
        cache_op_e   op;

        seed      = $urandom(32'h031532d4);
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        wb_ack    = 1'b0;
        wb_dat    = '0;

        repeat (3) @(negedge clk);
        assert (!req_ready && !resp_valid && !wb_m2s.cyc && !wb_m2s.stb)
            else stop_run("outputs not idle during reset");
        rstn = 1'b1;
        @(negedge clk);
        assert (req_ready) else stop_run("req_ready did not rise in the first cycle after reset");

        fd = $fopen("verif/icache_stim.txt", "r");
        assert (fd != 0) else stop_run("cannot open verif/icache_stim.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 2 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %d", op_name, addr, miss);
                assert (n == 3) else stop_run({"malformed stim line: ", line});
                if (op_name == "fetch") begin
                    op = op_fetch;
                end else if (op_name == "init") begin
                    op = op_init_index;
                end else if (op_name == "inval") begin
                    op = op_inval_index;
                end else if (op_name == "hitinv") begin
                    op = op_inval_hit;
                end else begin
                    stop_run({"unknown op in stim file: ", op_name});
                end
                send_request(op, addr, miss[0]);
            end
        end
        $fclose(fd);
        req_valid = 1'b0;

        // let the last refill finish
        waited = 0;
        while (exp_addr_q.size() > 0) begin
            waited++;
            assert (waited < timeout_cycles)
                else stop_run("timeout waiting for the last responses");
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // catch stray responses

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- hw/icache_top.sv
`timescale 1ns/10ps

module icache_top #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    input  icache_pkg::icache_req_t req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output logic [31:0]             resp_data,
    output icache_pkg::wb_m2s_t     wb_m2s,
    input  logic                    wb_ack,
    input  logic [31:0]             wb_dat
);
    import icache_pkg::*;

    icache_req_t             lk_req;
    logic                    lk_valid;
    logic                    stage_adv;
    logic [1:0]              hit;
    logic [1:0]              tag_we;
    logic [1:0]              data_we;
    logic [1:0]              inval_way;
    logic [offset_width-1:0] refill_word;
    logic                    lru_touch;
    logic                    touch_way;
    logic                    victim;
    logic [31:0]             hit_data;

    ////////////////////////////////////////////////////////////////////////////
    // request stage, then lookup against both arrays
    ////////////////////////////////////////////////////////////////////////////

    icache_req_stage req_stage_i (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .stage_adv (stage_adv),
        .lk_valid  (lk_valid),
        .lk_req    (lk_req)
    );

    icache_tagv_array #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) tagv_i (
        .clk       (clk),
        .rstn      (rstn),
        .lk_req    (lk_req),
        .tag_we    (tag_we),
        .inval_way (inval_way),
        .hit       (hit)
    );

    icache_data_lru #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) data_lru_i (
        .clk         (clk),
        .rstn        (rstn),
        .lk_req      (lk_req),
        .hit         (hit),
        .data_we     (data_we),
        .refill_word (refill_word),
        .wb_dat      (wb_dat),
        .lru_touch   (lru_touch),
        .touch_way   (touch_way),
        .hit_data    (hit_data),
        .victim      (victim)
    );

    icache_ctrl_fsm #(
        .offset_width (offset_width)
    ) ctrl_i (
        .clk         (clk),
        .rstn        (rstn),
        .lk_valid    (lk_valid),
        .lk_req      (lk_req),
        .hit         (hit),
        .victim      (victim),
        .hit_data    (hit_data),
        .wb_m2s      (wb_m2s),
        .wb_ack      (wb_ack),
        .wb_dat      (wb_dat),
        .stage_adv   (stage_adv),
        .tag_we      (tag_we),
        .data_we     (data_we),
        .refill_word (refill_word),
        .inval_way   (inval_way),
        .lru_touch   (lru_touch),
        .touch_way   (touch_way),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data)
    );

endmodule

//--- hw/icache_ctrl_fsm.sv
`timescale 1ns/10ps

module icache_ctrl_fsm #(
    parameter int offset_width = 2
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    lk_valid,
    input  icache_pkg::icache_req_t lk_req,
    input  logic [1:0]              hit,
    input  logic                    victim,
    input  logic [31:0]             hit_data,
    output icache_pkg::wb_m2s_t     wb_m2s,
    input  logic                    wb_ack,
    input  logic [31:0]             wb_dat,
    output logic                    stage_adv,
    output logic [1:0]              tag_we,
    output logic [1:0]              data_we,
    output logic [offset_width-1:0] refill_word,
    output logic [1:0]              inval_way,
    output logic                    lru_touch,
    output logic                    touch_way,
    output logic                    resp_valid,
    output logic [31:0]             resp_data
);
    import icache_pkg::*;

    fsm_state_e              state;
    fsm_state_e              state_nxt;
    fsm_state_e              cur_state;   // state with ops split out of lookup
    logic [offset_width-1:0] refill_cnt;
    logic [offset_width-1:0] req_word;
    logic                    victim_q;
    logic [31:0]             miss_word;
    logic                    lk_miss;

    assign req_word    = lk_req.addr[offset_width+1:2];
    assign refill_word = refill_cnt;

    // an op in the lookup stage is handled in that same cycle
    always_comb begin
        cur_state = state;
        if (state == st_lookup && lk_valid && lk_req.op != op_fetch) begin
            cur_state = st_op;
        end
    end

    assign lk_miss = (cur_state == st_lookup) && lk_valid && (hit == 2'b00);

    ////////////////////////////////////////////////////////////////////////////
    // state and refill bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            refill_cnt <= '0;
            victim_q   <= 1'b0;
        end else if (lk_miss) begin
            refill_cnt <= '0;          // refill starts at the line base
            victim_q   <= victim;
        end else if (state == st_miss_req && wb_ack) begin
            refill_cnt <= refill_cnt + 1'b1;
        end
    end

    // keep the requested word as it goes past
    always_ff @(posedge clk) begin
        if (state == st_miss_req && wb_ack && refill_cnt == req_word) begin
            miss_word <= wb_dat;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt  = state;
        stage_adv  = 1'b0;
        tag_we     = 2'b00;
        data_we    = 2'b00;
        inval_way  = 2'b00;
        lru_touch  = 1'b0;
        touch_way  = hit[1];
        resp_valid = 1'b0;
        resp_data  = hit_data;
        wb_m2s     = '0;
        wb_m2s.adr = {lk_req.addr[ADDR_W-1:offset_width+2], refill_cnt, 2'b00};

        case (cur_state)
            st_idle: begin
                state_nxt = st_lookup;   // ready comes up one cycle later
            end
            st_lookup: begin
                if (!lk_valid) begin
                    stage_adv = 1'b1;
                end else if (hit != 2'b00) begin
                    resp_valid = 1'b1;
                    lru_touch  = 1'b1;
                    stage_adv  = 1'b1;   // pipelined, next request goes in
                end else begin
                    state_nxt = st_miss_req;
                end
            end
            st_op: begin
                stage_adv = 1'b1;
                case (lk_req.op)
                    op_init_index, op_inval_index: begin
                        inval_way = {lk_req.addr[0], ~lk_req.addr[0]};
                    end
                    op_inval_hit: begin
                        inval_way = hit;   // nothing happens on a miss
                    end
                    default: begin
                        inval_way = 2'b00;
                    end
                endcase
            end
            st_miss_req: begin
                wb_m2s.cyc = 1'b1;
                wb_m2s.stb = 1'b1;
                if (wb_ack) begin
                    data_we[victim_q] = 1'b1;
                    if (&refill_cnt) begin
                        state_nxt = st_miss_wait;
                    end
                end
            end
            st_miss_wait: begin
                // last cycle of a refill, line becomes valid here
                tag_we[victim_q] = 1'b1;
                resp_valid       = 1'b1;
                resp_data        = miss_word;
                lru_touch        = 1'b1;
                touch_way        = victim_q;
                stage_adv        = 1'b1;
                state_nxt        = st_lookup;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    a_stb_cyc: assert property (
        @(posedge clk) disable iff (!rstn)
        wb_m2s.stb |-> wb_m2s.cyc
    );

    // classic cycle, strobe and address hold until the slave acks
    a_adr_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        wb_m2s.stb && !wb_ack |=> wb_m2s.stb && $stable(wb_m2s.adr)
    );

endmodule

//--- hw/icache_data_lru.sv
`timescale 1ns/10ps

module icache_data_lru #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  icache_pkg::icache_req_t lk_req,
    input  logic [1:0]              hit,
    input  logic [1:0]              data_we,
    input  logic [offset_width-1:0] refill_word,
    input  logic [31:0]             wb_dat,
    input  logic                    lru_touch,
    input  logic                    touch_way,
    output logic [31:0]             hit_data,
    output logic                    victim
);

    localparam int sets  = 2 ** index_width;
    localparam int depth = 2 ** (index_width + offset_width);

    logic [index_width-1:0]  idx;
    logic [offset_width-1:0] word;
    logic [31:0]             rd_data [2];
    logic [sets-1:0]         lru_q;   // set bit = way 1 goes next

    assign idx  = lk_req.addr[offset_width+2 +: index_width];
    assign word = lk_req.addr[offset_width+1:2];

    ////////////////////////////////////////////////////////////////////////////
    // line words, addressed as {set, word}
    ////////////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [31:0] data_mem [depth];

        always_ff @(posedge clk) begin
            if (data_we[w]) begin
                data_mem[{idx, refill_word}] <= wb_dat;   // one word per ack
            end
        end

        assign rd_data[w] = data_mem[{idx, word}];
    end

    assign hit_data = hit[1] ? rd_data[1] : rd_data[0];

    ////////////////////////////////////////////////////////////////////////////
    // one LRU bit per set
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (lru_touch) begin
            lru_q[idx] <= ~touch_way;   // the other way is now the victim
        end
    end

    assign victim = lru_q[idx];

endmodule

//--- hw/icache_tagv_array.sv
`timescale 1ns/10ps

module icache_tagv_array #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  icache_pkg::icache_req_t lk_req,
    input  logic [1:0]              tag_we,
    input  logic [1:0]              inval_way,
    output logic [1:0]              hit
);
    import icache_pkg::*;

    localparam int tag_w = ADDR_W - index_width - offset_width - 2;
    localparam int sets  = 2 ** index_width;

    logic [index_width-1:0] idx;
    logic [tag_w-1:0]       lk_tag;

    assign idx    = lk_req.addr[offset_width+2 +: index_width];
    assign lk_tag = lk_req.addr[ADDR_W-1 -: tag_w];

    ////////////////////////////////////////////////////////////////////////////
    // per-way tag and valid storage
    ////////////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [tag_w-1:0] tag_mem [sets];
        logic [sets-1:0]  valid_q;

        always_ff @(posedge clk) begin
            if (tag_we[w]) begin
                tag_mem[idx] <= lk_tag;
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= '0;
            end else if (tag_we[w]) begin
                valid_q[idx] <= 1'b1;   // line refilled
            end else if (inval_way[w]) begin
                valid_q[idx] <= 1'b0;   // any of the three ops
            end
        end

        // combinational compare, answered in the lookup cycle
        assign hit[w] = valid_q[idx] && (tag_mem[idx] == lk_tag);
    end

    // a line must never be resident in both ways of a set
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        hit != 2'b11
    );

endmodule

//--- hw/icache_req_stage.sv
`timescale 1ns/10ps

module icache_req_stage (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    input  icache_pkg::icache_req_t req,
    output logic                    req_ready,
    input  logic                    stage_adv,
    output logic                    lk_valid,
    output icache_pkg::icache_req_t lk_req
);

    // the stage only takes a new request when the lookup stage moves on
    assign req_ready = stage_adv;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lk_valid <= 1'b0;
            lk_req   <= '0;       // keeps the array index defined out of reset
        end else if (stage_adv) begin
            lk_valid <= req_valid;   // drops to 0 when nothing is offered
            if (req_valid) begin
                lk_req <= req;
            end
        end
    end

    // a request held in lookup (miss refill) must not change under the FSM
    a_lk_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        lk_valid && !stage_adv |=> $stable(lk_req)
    );

endmodule

//--- hw/icache_pkg.sv
package icache_pkg;

    localparam int ADDR_W = 32;

    // maintenance ops share the request channel with fetches
    typedef enum logic [1:0] {
        op_fetch       = 2'd0,
        op_init_index  = 2'd1,
        op_inval_index = 2'd2,
        op_inval_hit   = 2'd3
    } cache_op_e;

    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_lookup    = 3'd1,
        st_op        = 3'd2,
        st_miss_req  = 3'd3,
        st_miss_wait = 3'd4
    } fsm_state_e;

    typedef struct packed {
        cache_op_e         op;
        logic [ADDR_W-1:0] addr;   // byte address of a word, bit 0 picks the way for index ops
    } icache_req_t;

    // wishbone classic master outputs
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;    // always 0, reads only
        logic [ADDR_W-1:0] adr;
    } wb_m2s_t;

endpackage
